// File: common/camera_pkg.sv
`default_nettype none

package camera_pkg;

    ///////////////////////////////
    // pixel widths
    ///////////////////////////////
    localparam int PIXEL_BITS   = 9;   // rgb333 as stored in the frame buffer
    localparam int RGB_OUT_BITS = 12;  // rgb444 toward the monitor
    localparam int CHAN_BITS    = 3;   // bits per channel kept in the buffer
    localparam int COUNT_BITS   = 10;  // vga pixel/line counters, 800x525 fits

    ///////////////////////////////
    // field layout
    ///////////////////////////////
    // rgb565 from the sensor, msb of each field
    localparam int RGB565_R_MSB = 15;  // r[15:11]
    localparam int RGB565_G_MSB = 10;  // g[10:5]
    localparam int RGB565_B_MSB = 4;   // b[4:0]

    // rgb333 in the buffer
    localparam int RGB333_R_MSB = 8;   // r[8:6]
    localparam int RGB333_G_MSB = 5;   // g[5:3]
    localparam int RGB333_B_MSB = 2;   // b[2:0]

    ///////////////////////////////
    // capture control
    ///////////////////////////////
    typedef enum logic [1:0] {
        CAP_IDLE,  // nothing requested yet
        CAP_ARM,   // request seen, waiting for vsync to fall
        CAP_GRAB,  // inside the frame, writing pixels
        CAP_DONE   // frame stored, done held high
    } capture_state_e;

    // which byte of the rgb565 pair comes next
    typedef enum logic {
        PHASE_HIGH,
        PHASE_LOW
    } byte_phase_e;

endpackage

`default_nettype wire

// File: camera/camera_capture.sv
`timescale 1ns/10ps
`default_nettype none

module camera_capture #(
    parameter int FB_WIDTH  = 240,
    parameter int FB_HEIGHT = 240,
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT,
    localparam int ADDR_BITS = $clog2(FB_DEPTH)
) (
    input  wire                                 camera_pclk,
    input  wire                                 rst,
    input  wire                                 capture_frame,  // request pulse
    input  wire                                 camera_vsync,
    input  wire                                 camera_href,
    input  wire  [7:0]                          camera_data,
    output logic                                wr_en,
    output logic [ADDR_BITS-1:0]                wr_addr,
    output logic [camera_pkg::PIXEL_BITS-1:0]   wr_data,
    output logic                                capture_done
);
    import camera_pkg::*;

    // counters saturate at the window edge so need one extra bit
    localparam int COL_BITS = $clog2(FB_WIDTH + 1);
    localparam int ROW_BITS = $clog2(FB_HEIGHT + 1);
    localparam logic [COL_BITS-1:0] COL_MAX = COL_BITS'(FB_WIDTH);
    localparam logic [ROW_BITS-1:0] ROW_MAX = ROW_BITS'(FB_HEIGHT);

    capture_state_e       state;
    byte_phase_e          phase;
    logic                 vsync_d, href_d;
    logic                 vsync_fall, vsync_rise, href_fall;
    logic [COL_BITS-1:0]  col;
    logic [ROW_BITS-1:0]  row;
    logic [7:0]           hi_byte;   // first half of the pixel
    logic [15:0]          pixel565;
    logic                 in_window;

    assign vsync_fall = vsync_d & ~camera_vsync;   // frame starts
    assign vsync_rise = ~vsync_d & camera_vsync;   // frame ends
    assign href_fall  = href_d & ~camera_href;     // line ends

    assign pixel565  = {hi_byte, camera_data};
    assign in_window = (col < COL_MAX) && (row < ROW_MAX);

    assign capture_done = (state == CAP_DONE);

    ///////////////////////////////
    // capture fsm
    ///////////////////////////////
    always_ff @(posedge camera_pclk) begin
        if (rst) begin
            state   <= CAP_IDLE;
            vsync_d <= 1'b0;
            href_d  <= 1'b0;
        end else begin
            vsync_d <= camera_vsync;
            href_d  <= camera_href;
            case (state)
                CAP_IDLE: if (capture_frame) state <= CAP_ARM;
                CAP_ARM:  if (vsync_fall) state <= CAP_GRAB;
                CAP_GRAB: if (vsync_rise) state <= CAP_DONE;  // request ignored here
                CAP_DONE: if (capture_frame) state <= CAP_ARM;
                default:  state <= CAP_IDLE;
            endcase
        end
    end

    ///////////////////////////////
    // byte pairing, position
    ///////////////////////////////
    always_ff @(posedge camera_pclk) begin
        if (rst) begin
            phase <= PHASE_HIGH;
            col   <= '0;
            row   <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (vsync_fall) begin               // new frame restarts at top left
                phase <= PHASE_HIGH;
                col   <= '0;
                row   <= '0;
            end else if (href_fall) begin
                phase <= PHASE_HIGH;
                col   <= '0;
                if (row != ROW_MAX) row <= row + 1'b1;
            end else if (camera_href) begin
                if (phase == PHASE_HIGH) begin
                    phase <= PHASE_LOW;
                end else begin
                    phase <= PHASE_HIGH;
                    if (col != COL_MAX) col <= col + 1'b1;
                    // write only inside the window and before the frame closes
                    wr_en <= (state == CAP_GRAB) && in_window && !vsync_rise;
                end
            end
        end
    end

    // payload path
    always_ff @(posedge camera_pclk) begin
        if (camera_href && phase == PHASE_HIGH) hi_byte <= camera_data;
        if (camera_href && phase == PHASE_LOW) begin
            wr_addr <= ADDR_BITS'(row) * ADDR_BITS'(FB_WIDTH) + ADDR_BITS'(col);
            // keep top 3 bits of every channel
            wr_data <= {pixel565[RGB565_R_MSB -: CHAN_BITS],
                        pixel565[RGB565_G_MSB -: CHAN_BITS],
                        pixel565[RGB565_B_MSB -: CHAN_BITS]};
        end
    end

    ///////////////////////////////
    // checks
    ///////////////////////////////
    a_wr_in_grab: assert property (@(posedge camera_pclk) disable iff (rst)
        wr_en |-> state == CAP_GRAB)
        else $error("wr_en outside grab");

    a_wr_addr_range: assert property (@(posedge camera_pclk) disable iff (rst)
        wr_en |-> int'(wr_addr) < FB_DEPTH)
        else $error("wr_addr 0x%0h past buffer end", wr_addr);

endmodule

`default_nettype wire

// File: hdl/frame_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module frame_buffer #(
    parameter int FB_WIDTH  = 240,
    parameter int FB_HEIGHT = 240,
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT,
    localparam int ADDR_BITS = $clog2(FB_DEPTH)
) (
    input  wire                                 clk_write,  // camera_pclk side
    input  wire                                 clk_read,   // clk_50 side
    input  wire                                 wr_en,
    input  wire  [ADDR_BITS-1:0]                wr_addr,
    input  wire  [camera_pkg::PIXEL_BITS-1:0]   wr_data,
    input  wire  [ADDR_BITS-1:0]                rd_addr,
    output logic [camera_pkg::PIXEL_BITS-1:0]   rd_data
);
    import camera_pkg::*;

    // one rgb333 word per pixel of the window
    logic [PIXEL_BITS-1:0] mem [FB_DEPTH];

    ///////////////////////////////
    // write port
    ///////////////////////////////
    always_ff @(posedge clk_write) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ///////////////////////////////
    // read port
    ///////////////////////////////
    // registered, data one clk_read after the address
    always_ff @(posedge clk_read) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: vga/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire                                 clk_50,
    input  wire                                 rst,
    output logic [camera_pkg::COUNT_BITS-1:0]   hcount,     // pixel within line
    output logic [camera_pkg::COUNT_BITS-1:0]   vcount,     // line within frame
    output logic                                hsync_raw,  // active low
    output logic                                vsync_raw,  // active low
    output logic                                blank_raw
);
    import camera_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // positions in counter width
    localparam logic [COUNT_BITS-1:0] H_LAST     = COUNT_BITS'(H_TOTAL - 1);
    localparam logic [COUNT_BITS-1:0] V_LAST     = COUNT_BITS'(V_TOTAL - 1);
    localparam logic [COUNT_BITS-1:0] H_ACT      = COUNT_BITS'(H_ACTIVE);
    localparam logic [COUNT_BITS-1:0] V_ACT      = COUNT_BITS'(V_ACTIVE);
    localparam logic [COUNT_BITS-1:0] HS_START   = COUNT_BITS'(H_ACTIVE + H_FRONT);
    localparam logic [COUNT_BITS-1:0] HS_END     = COUNT_BITS'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [COUNT_BITS-1:0] VS_START   = COUNT_BITS'(V_ACTIVE + V_FRONT);
    localparam logic [COUNT_BITS-1:0] VS_END     = COUNT_BITS'(V_ACTIVE + V_FRONT + V_SYNC);

    ///////////////////////////////
    // counters
    ///////////////////////////////
    always_ff @(posedge clk_50) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == H_LAST) begin
            hcount <= '0;   // wrap line
            if (vcount == V_LAST) begin
                vcount <= '0;   // wrap frame
            end else begin
                vcount <= vcount + 1'b1;
            end
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    ///////////////////////////////
    // sync and blank
    ///////////////////////////////
    // decoded straight from the counters, reader registers them
    always_comb begin
        hsync_raw = !((hcount >= HS_START) && (hcount < HS_END));  // after front porch
        vsync_raw = !((vcount >= VS_START) && (vcount < VS_END));
        blank_raw = (hcount >= H_ACT) || (vcount >= V_ACT);
    end

    a_hcount_range: assert property (@(posedge clk_50) disable iff (rst)
        int'(hcount) < H_TOTAL)
        else $error("hcount 0x%0h past line total", hcount);

endmodule

`default_nettype wire

// File: vga/vga_pixel_reader.sv
`timescale 1ns/10ps
`default_nettype none

module vga_pixel_reader #(
    parameter int FB_WIDTH  = 240,
    parameter int FB_HEIGHT = 240,
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT,
    localparam int ADDR_BITS = $clog2(FB_DEPTH)
) (
    input  wire                                 clk_50,
    input  wire                                 rst,
    input  wire  [camera_pkg::COUNT_BITS-1:0]   hcount,
    input  wire  [camera_pkg::COUNT_BITS-1:0]   vcount,
    input  wire                                 hsync_raw,
    input  wire                                 vsync_raw,
    input  wire                                 blank_raw,
    input  wire  [camera_pkg::PIXEL_BITS-1:0]   rd_data,    // one clock after rd_addr
    output logic [ADDR_BITS-1:0]                rd_addr,
    output logic [camera_pkg::RGB_OUT_BITS-1:0] vga_rgb,
    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                vga_blank
);
    import camera_pkg::*;

    localparam logic [COUNT_BITS-1:0] WIN_W = COUNT_BITS'(FB_WIDTH);
    localparam logic [COUNT_BITS-1:0] WIN_H = COUNT_BITS'(FB_HEIGHT);

    logic                  in_window;
    logic                  window_d1, hsync_d1, vsync_d1, blank_d1;  // stage 1
    logic [CHAN_BITS-1:0]  red3, green3, blue3;

    ///////////////////////////////
    // read address
    ///////////////////////////////
    always_comb begin
        in_window = !blank_raw && (hcount < WIN_W) && (vcount < WIN_H);
        // outside the window park on word 0
        if (in_window) begin
            rd_addr = ADDR_BITS'(vcount) * ADDR_BITS'(FB_WIDTH) + ADDR_BITS'(hcount);
        end else begin
            rd_addr = '0;
        end
    end

    // channel split of the buffer word
    assign red3   = rd_data[RGB333_R_MSB -: CHAN_BITS];
    assign green3 = rd_data[RGB333_G_MSB -: CHAN_BITS];
    assign blue3  = rd_data[RGB333_B_MSB -: CHAN_BITS];

    ///////////////////////////////
    // 2 stage output pipe
    ///////////////////////////////
    always_ff @(posedge clk_50) begin
        if (rst) begin
            window_d1 <= 1'b0;
            hsync_d1  <= 1'b1;   // syncs idle high
            vsync_d1  <= 1'b1;
            blank_d1  <= 1'b1;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_blank <= 1'b1;
            vga_rgb   <= '0;
        end else begin
            // stage 1 lines up with rd_data
            window_d1 <= in_window;
            hsync_d1  <= hsync_raw;
            vsync_d1  <= vsync_raw;
            blank_d1  <= blank_raw;
            // stage 2, the outputs
            vga_hsync <= hsync_d1;
            vga_vsync <= vsync_d1;
            vga_blank <= blank_d1;
            if (window_d1) begin
                // 3 to 4 bits, top bit copied into the new lsb
                vga_rgb <= {red3, red3[CHAN_BITS-1],
                            green3, green3[CHAN_BITS-1],
                            blue3, blue3[CHAN_BITS-1]};
            end else begin
                vga_rgb <= '0;   // black outside window or in blanking
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/camera_vga_top.sv
`timescale 1ns/10ps
`default_nettype none

module camera_vga_top #(
    parameter int FB_WIDTH  = 240,
    parameter int FB_HEIGHT = 240,
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire                                 clk_50,
    input  wire                                 camera_pclk,
    input  wire                                 rst,
    input  wire                                 capture_frame,
    input  wire                                 camera_href,
    input  wire                                 camera_vsync,
    input  wire  [7:0]                          camera_data,
    output logic                                capture_done,
    output logic [camera_pkg::RGB_OUT_BITS-1:0] vga_rgb,
    output logic                                vga_hsync,
    output logic                                vga_vsync,
    output logic                                vga_blank
);
    import camera_pkg::*;

    localparam int ADDR_BITS = $clog2(FB_WIDTH * FB_HEIGHT);

    // camera side into the buffer
    logic                   wr_en;
    logic [ADDR_BITS-1:0]   wr_addr;
    logic [PIXEL_BITS-1:0]  wr_data;
    // vga side out of the buffer
    logic [ADDR_BITS-1:0]   rd_addr;
    logic [PIXEL_BITS-1:0]  rd_data;
    // raw timing, not yet delayed
    logic [COUNT_BITS-1:0]  hcount, vcount;
    logic                   hsync_raw, vsync_raw, blank_raw;

    ///////////////////////////////
    // pixel clock domain
    ///////////////////////////////
    camera_capture #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) get_a_frame (
        .camera_pclk   (camera_pclk),
        .rst           (rst),
        .capture_frame (capture_frame),
        .camera_vsync  (camera_vsync),
        .camera_href   (camera_href),
        .camera_data   (camera_data),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .capture_done  (capture_done)
    );

    // the only crossing between the two clocks
    frame_buffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) video_mem (
        .clk_write (camera_pclk),
        .clk_read  (clk_50),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    ///////////////////////////////
    // vga clock domain
    ///////////////////////////////
    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_signal_gen (
        .clk_50    (clk_50),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .blank_raw (blank_raw)
    );

    vga_pixel_reader #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) pixel_read (
        .clk_50    (clk_50),
        .rst       (rst),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .blank_raw (blank_raw),
        .rd_data   (rd_data),
        .rd_addr   (rd_addr),
        .vga_rgb   (vga_rgb),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_blank (vga_blank)
    );

endmodule

`default_nettype wire

// File: tb/camera_sensor_model.sv
`timescale 1ns/10ps
`default_nettype none

module camera_sensor_model #(
    parameter int          FRAME_W = 20,
    parameter int          FRAME_H = 14,
    parameter logic [31:0] SEED    = 32'h7f35_f87f
) (
    input  wire        camera_pclk,
    input  wire        send_frame,    // sampled on the rising edge
    output logic       camera_vsync,  // high in vertical blanking
    output logic       camera_href,
    output logic [7:0] camera_data,
    output logic       busy           // high while a frame goes out
);

    localparam int LINE_GAP  = 6;   // href low between lines
    localparam int FRAME_GAP = 4;   // margin around the vsync edges

    // rgb565 pixels of the frame being sent, row major
    logic [15:0] pixels [FRAME_W*FRAME_H];
    logic [31:0] lfsr;

    // galois form, shifts right, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0000_0000);
    endfunction

    // new pattern, one lfsr step per pixel bit
    task automatic fill_pattern();
        logic [15:0] px;
        for (int i = 0; i < FRAME_W*FRAME_H; i++) begin
            px = '0;
            for (int b = 0; b < 16; b++) begin
                px   = {px[14:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
            pixels[i] = px;
        end
    endtask

    task automatic idle_clocks(input int n);
        repeat (n) @(negedge camera_pclk);
    endtask

    //////////////////////////////
    // one frame on the bus
    //////////////////////////////
    task automatic send_one_frame();
        idle_clocks(FRAME_GAP);            // vsync still high
        @(negedge camera_pclk);
        camera_vsync = 1'b0;               // frame start
        idle_clocks(FRAME_GAP);
        for (int row = 0; row < FRAME_H; row++) begin
            for (int col = 0; col < FRAME_W; col++) begin
                @(negedge camera_pclk);
                camera_href = 1'b1;
                camera_data = pixels[row*FRAME_W + col][15:8];  // high byte first
                @(negedge camera_pclk);
                camera_data = pixels[row*FRAME_W + col][7:0];
            end
            @(negedge camera_pclk);
            camera_href = 1'b0;
            camera_data = 8'h00;
            idle_clocks(LINE_GAP - 1);
        end
        idle_clocks(FRAME_GAP);
        @(negedge camera_pclk);
        camera_vsync = 1'b1;               // frame end
        idle_clocks(FRAME_GAP);
    endtask

    initial begin
        camera_vsync = 1'b1;
        camera_href  = 1'b0;
        camera_data  = 8'h00;
        busy         = 1'b0;
        lfsr         = SEED;
        forever begin
            @(posedge camera_pclk);
            if (send_frame) begin
                busy = 1'b1;
                fill_pattern();
                send_one_frame();
                @(posedge camera_pclk);
                busy = 1'b0;       // away from the falling edge
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_camera_vga.sv
`timescale 1ns/10ps
`default_nettype none

module tb_camera_vga;

    localparam int FB_W     = 16;
    localparam int FB_H     = 12;
    localparam int H_ACTIVE = 32;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 6;
    localparam int H_BACK   = 6;
    localparam int V_ACTIVE = 24;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 3;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CLOCKS = H_TOTAL * V_TOTAL;
    localparam int SENSOR_W = 20;   // wider and taller than the window
    localparam int SENSOR_H = 14;
    localparam int PCLK_LIMIT = 2000;  // pclk cycles for any camera wait

    logic        clk_50, camera_pclk, rst;
    logic        capture_frame, send_frame, sensor_busy;
    logic        camera_vsync, camera_href;
    logic [7:0]  camera_data;
    logic        capture_done, vga_hsync, vga_vsync, vga_blank;
    logic [11:0] vga_rgb;
    logic [15:0] shown [SENSOR_W*SENSOR_H];  // sensor frame that was captured

    always #5 clk_50 = ~clk_50;
    always #7 camera_pclk = ~camera_pclk;  // unrelated to clk_50

    camera_vga_top #(
        .FB_WIDTH (FB_W),     .FB_HEIGHT (FB_H),
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) UUT (
        .clk_50 (clk_50), .camera_pclk (camera_pclk), .rst (rst),
        .capture_frame (capture_frame), .camera_href (camera_href),
        .camera_vsync (camera_vsync), .camera_data (camera_data),
        .capture_done (capture_done), .vga_rgb (vga_rgb),
        .vga_hsync (vga_hsync), .vga_vsync (vga_vsync), .vga_blank (vga_blank)
    );

    camera_sensor_model #(.FRAME_W (SENSOR_W), .FRAME_H (SENSOR_H)) sensor (
        .camera_pclk (camera_pclk), .send_frame (send_frame),
        .camera_vsync (camera_vsync), .camera_href (camera_href),
        .camera_data (camera_data), .busy (sensor_busy)
    );

    //////////////////////////////
    // failure reporting
    //////////////////////////////
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s", what);
        abort_run();
    endtask

    // no color may leak into blanking
    blank_is_black: assert property (@(posedge clk_50) disable iff (rst)
        vga_blank |-> vga_rgb == '0)
        else report_mismatch("vga_rgb", 32'($sampled(vga_rgb)), 32'h0);

    // rgb565 -> top 3 bits per channel -> msb repeated as new lsb
    function automatic logic [11:0] expected_rgb(input int row, input int col);
        logic [15:0] p;
        logic [2:0]  r, g, b;
        if (row >= FB_H || col >= FB_W) return 12'h000;  // outside the window
        p = shown[row*SENSOR_W + col];
        r = p[15:13];
        g = p[10:8];
        b = p[4:2];
        return {r, r[2], g, g[2], b, b[2]};
    endfunction

    //////////////////////////////
    // vga side waits
    //////////////////////////////
    task automatic wait_vga_sync(input bit vertical, input logic level, input int limit);
        int   n;
        logic s;
        n = 0;
        s = vertical ? vga_vsync : vga_hsync;
        while (s !== level) begin
            if (n == limit) report_error("timeout waiting for a vga sync level");
            @(negedge clk_50);
            n++;
            s = vertical ? vga_vsync : vga_hsync;
        end
    endtask

    // clocks the sync stays at its current level
    task automatic measure_level(input bit vertical, input logic level, input int limit,
                                 output int clocks);
        logic s;
        clocks = 0;
        s = vertical ? vga_vsync : vga_hsync;
        while (s === level) begin
            if (clocks == limit) report_error("sync level held too long");
            @(negedge clk_50);
            clocks++;
            s = vertical ? vga_vsync : vga_hsync;
        end
    endtask

    task automatic check_sync_timing();
        int low, high;
        wait_vga_sync(1'b0, 1'b1, H_TOTAL * 2);
        wait_vga_sync(1'b0, 1'b0, H_TOTAL * 2);   // hsync just fell
        measure_level(1'b0, 1'b0, H_TOTAL, low);
        measure_level(1'b0, 1'b1, H_TOTAL, high);
        assert (low == H_SYNC) else report_mismatch("hsync low width", low, H_SYNC);
        assert (low + high == H_TOTAL) else report_mismatch("hsync period", low + high, H_TOTAL);
        wait_vga_sync(1'b1, 1'b0, FRAME_CLOCKS * 2);
        measure_level(1'b1, 1'b0, FRAME_CLOCKS, low);
        measure_level(1'b1, 1'b1, FRAME_CLOCKS, high);
        assert (low == V_SYNC * H_TOTAL)
            else report_mismatch("vsync low clocks", low, V_SYNC * H_TOTAL);
        assert (low + high == FRAME_CLOCKS)
            else report_mismatch("vsync period", low + high, FRAME_CLOCKS);
    endtask

    // walk one full frame, lines found by blank falling after vsync
    task automatic scan_frame();
        int          row, col, n;
        logic        blank_prev;
        logic [11:0] exp;
        wait_vga_sync(1'b1, 1'b0, FRAME_CLOCKS * 2);
        wait_vga_sync(1'b1, 1'b1, FRAME_CLOCKS);
        row = -1;
        col = 0;
        n = 0;
        blank_prev = 1'b1;
        while (vga_vsync === 1'b1) begin
            if (vga_blank === 1'b0) begin
                if (blank_prev) begin
                    row++;
                    col = 0;
                end
                exp = expected_rgb(row, col);
                assert (vga_rgb === exp) else report_mismatch("vga_rgb", 32'(vga_rgb), 32'(exp));
                col++;
            end else if (!blank_prev) begin
                assert (col == H_ACTIVE) else report_mismatch("pixels per line", col, H_ACTIVE);
            end
            blank_prev = vga_blank;
            if (n == FRAME_CLOCKS) report_error("timeout scanning a vga frame");
            @(negedge clk_50);
            n++;
        end
        assert (row + 1 == V_ACTIVE) else report_mismatch("active lines", row + 1, V_ACTIVE);
    endtask

    //////////////////////////////
    // camera side
    //////////////////////////////
    task automatic start_sensor_frame();
        int n;
        n = 0;
        @(negedge camera_pclk);
        send_frame = 1'b1;
        @(negedge camera_pclk);
        send_frame = 1'b0;
        while (sensor_busy !== 1'b1) begin
            if (n == PCLK_LIMIT) report_error("sensor model did not start a frame");
            @(negedge camera_pclk);
            n++;
        end
    endtask

    task automatic wait_sensor_idle();
        int n;
        n = 0;
        while (sensor_busy !== 1'b0) begin
            if (n == PCLK_LIMIT) report_error("sensor model never finished its frame");
            @(negedge camera_pclk);
            n++;
        end
    endtask

    task automatic capture_one_frame();
        int n;
        @(negedge camera_pclk);
        capture_frame = 1'b1;
        @(negedge camera_pclk);
        capture_frame = 1'b0;
        assert (capture_done === 1'b0) else report_mismatch("capture_done", 32'(capture_done), 0);
        start_sensor_frame();
        n = 0;
        while (capture_done !== 1'b1) begin
            if (n == PCLK_LIMIT) report_error("capture_done never rose after the request");
            @(negedge camera_pclk);
            n++;
        end
        wait_sensor_idle();
        for (int i = 0; i < SENSOR_W*SENSOR_H; i++) shown[i] = sensor.pixels[i];
    endtask

    initial begin
        int diffs;
        clk_50        = 1'b0;
        camera_pclk   = 1'b0;
        rst           = 1'b1;
        capture_frame = 1'b0;
        send_frame    = 1'b0;
        repeat (16) @(negedge clk_50);
        // still in reset, both domains have seen enough edges
        assert (capture_done === 1'b0) else report_mismatch("capture_done", 32'(capture_done), 0);
        assert (vga_blank === 1'b1) else report_mismatch("vga_blank", 32'(vga_blank), 1);
        assert (vga_hsync === 1'b1) else report_mismatch("vga_hsync", 32'(vga_hsync), 1);
        assert (vga_vsync === 1'b1) else report_mismatch("vga_vsync", 32'(vga_vsync), 1);
        assert (vga_rgb === 12'h000) else report_mismatch("vga_rgb", 32'(vga_rgb), 0);
        rst = 1'b0;

        check_sync_timing();
        capture_one_frame();
        scan_frame();

        // new pattern but no request, picture must stay
        start_sensor_frame();
        wait_sensor_idle();
        diffs = 0;
        for (int i = 0; i < SENSOR_W*SENSOR_H; i++) if (sensor.pixels[i] != shown[i]) diffs++;
        assert (diffs > 0) else report_error("sensor sent the same pattern twice");
        assert (capture_done === 1'b1) else report_mismatch("capture_done", 32'(capture_done), 1);
        scan_frame();

        capture_one_frame();   // second request, fresh pattern
        scan_frame();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/camera_pkg.sv
camera/camera_capture.sv
hdl/frame_buffer.sv
vga/vga_timing.sv
vga/vga_pixel_reader.sv
hdl/camera_vga_top.sv
tb/camera_sensor_model.sv
tb/tb_camera_vga.sv

// File: Makefile
TOP := tb_camera_vga

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
